// File: common/system_pkg.sv
`default_nettype none

package system_pkg;

   // address widths
   localparam int ROM_ADDR_W = 13;
   localparam int RAM_ADDR_W = 16;
   localparam int IO_ADDR_W  = 4;
   localparam int BUTTON_W   = 5;

   // memory map
   localparam logic [15:0] ROM_BASE = 16'hC000;  // up to 0xffff
   localparam logic [15:0] RAM_LAST = 16'h8FFF;  // ram starts at 0x0000
   localparam logic [7:0]  IO_PAGE  = 8'h92;     // 0x92xx

   // io register indices
   localparam logic [IO_ADDR_W-1:0] IO_REG_BUTTONS = 4'd0;
   localparam logic [IO_ADDR_W-1:0] IO_REG_PRESSED = 4'd1;
   localparam logic [IO_ADDR_W-1:0] IO_REG_SCRATCH = 4'd2;
   localparam logic [IO_ADDR_W-1:0] IO_REG_MODE    = 4'd3;

   localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

   typedef enum logic [1:0] {
      REGION_RAM,
      REGION_ROM,
      REGION_IO,
      REGION_NONE
   } bus_region_e;

   typedef enum logic [1:0] {
      VGA_MODE_640x480   = 2'd1,
      VGA_MODE_800x600   = 2'd2,
      VGA_MODE_1920x1080 = 2'd3
   } vga_mode_e;

   // request from the bus master
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        wr_en;
      logic        rd_req;
   } cpu_bus_t;

endpackage

`default_nettype wire

// File: design/bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl import system_pkg::*; (
   input  wire                   sys_clk,
   input  wire                   reset_n,
   input  wire cpu_bus_t         cpu_bus,
   output logic [7:0]            rd_data,
   output logic                  ready,
   output logic [ROM_ADDR_W-1:0] rom_addr,
   input  wire  [7:0]            rom_rd_data,
   output logic [RAM_ADDR_W-1:0] ram_addr,
   output logic [7:0]            ram_wr_data,
   output logic                  ram_wr_en,
   input  wire  [7:0]            ram_rd_data,
   output logic [IO_ADDR_W-1:0]  io_addr,
   output logic [7:0]            io_wr_data,
   output logic                  io_wr_en,
   input  wire  [7:0]            io_rd_data
);

   typedef enum logic {
      BUS_IDLE,
      BUS_READ
   } bus_state_e;

   bus_state_e  bus_state;
   bus_region_e region;

   always_comb begin
      if (cpu_bus.addr >= ROM_BASE)
         region = REGION_ROM;
      else if (cpu_bus.addr <= RAM_LAST)
         region = REGION_RAM;
      else if (cpu_bus.addr[15:8] == IO_PAGE)
         region = REGION_IO;
      else
         region = REGION_NONE;  // video window and holes
   end

   assign rom_addr    = cpu_bus.addr[ROM_ADDR_W-1:0];
   assign ram_addr    = cpu_bus.addr[RAM_ADDR_W-1:0];
   assign io_addr     = cpu_bus.addr[IO_ADDR_W-1:0];
   assign ram_wr_data = cpu_bus.wr_data;
   assign io_wr_data  = cpu_bus.wr_data;

   // rom and unmapped writes go nowhere
   assign ram_wr_en = cpu_bus.wr_en && (region == REGION_RAM);
   assign io_wr_en  = cpu_bus.wr_en && (region == REGION_IO);

   always_comb begin
      case (region)
         REGION_ROM: rd_data = rom_rd_data;
         REGION_RAM: rd_data = ram_rd_data;
         REGION_IO:  rd_data = io_rd_data;
         default:    rd_data = UNMAPPED_DATA;
      endcase
   end

   // one wait cycle per read for the registered memory ports
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         bus_state <= BUS_IDLE;
      end else if (cpu_bus.rd_req) begin
         bus_state <= BUS_READ;
      end else begin
         bus_state <= BUS_IDLE;
      end
   end

   assign ready = (bus_state == BUS_IDLE);

endmodule

`default_nettype wire

// File: design/rom.sv
`timescale 1ns/1ps
`default_nettype none

module rom import system_pkg::*; (
   input  wire                   sys_clk,
   input  wire  [ROM_ADDR_W-1:0] addr,
   output logic [7:0]            rd_data
);

   logic [7:0] mem [0:(2**ROM_ADDR_W)-1];
   integer     i;

   initial begin
      for (i = 0; i < 2**ROM_ADDR_W; i = i + 1)
         mem[i] = 8'h00;  // hex file only covers the start
      $readmemh("design/rom_init.hex", mem);
   end

   always_ff @(posedge sys_clk) begin
      rd_data <= mem[addr];
   end

endmodule

`default_nettype wire

// File: design/spram.sv
`timescale 1ns/1ps
`default_nettype none

module spram import system_pkg::*; (
   input  wire                   sys_clk,
   input  wire  [RAM_ADDR_W-1:0] addr,
   input  wire  [7:0]            wr_data,
   input  wire                   wr_en,
   output logic [7:0]            rd_data
);

   logic [7:0] mem [0:(2**RAM_ADDR_W)-1];

   // read before write on the same address
   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[addr] <= wr_data;
      rd_data <= mem[addr];
   end

endmodule

`default_nettype wire

// File: design/io_board.sv
`timescale 1ns/1ps
`default_nettype none

module io_board import system_pkg::*; (
   input  wire                  sys_clk,
   input  wire                  reset_n,
   input  wire  [IO_ADDR_W-1:0] addr,
   input  wire  [7:0]           wr_data,
   input  wire                  wr_en,
   output logic [7:0]           rd_data,
   input  wire  [BUTTON_W-1:0]  buttons,
   input  wire  vga_mode_e      vga_mode
);

   logic [BUTTON_W-1:0] btn_meta;
   logic [BUTTON_W-1:0] btn_sync;
   logic [BUTTON_W-1:0] btn_prev;
   logic [BUTTON_W-1:0] btn_rise;
   logic [BUTTON_W-1:0] clr_mask;
   logic [BUTTON_W-1:0] pressed;
   logic [7:0]          scratch;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
         btn_prev <= '0;
      end else begin
         btn_meta <= buttons;
         btn_sync <= btn_meta;
         btn_prev <= btn_sync;
      end
   end

   assign btn_rise = btn_sync & ~btn_prev;
   assign clr_mask = (wr_en && addr == IO_REG_PRESSED) ? wr_data[BUTTON_W-1:0] : '0;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         pressed <= '0;
         scratch <= 8'h00;
      end else begin
         pressed <= (pressed & ~clr_mask) | btn_rise;  // new press beats clear
         if (wr_en && addr == IO_REG_SCRATCH)
            scratch <= wr_data;
      end
   end

   always_comb begin
      case (addr)
         IO_REG_BUTTONS: rd_data = {{(8-BUTTON_W){1'b0}}, btn_sync};
         IO_REG_PRESSED: rd_data = {{(8-BUTTON_W){1'b0}}, pressed};
         IO_REG_SCRATCH: rd_data = scratch;
         IO_REG_MODE:    rd_data = {6'b000000, vga_mode};
         default:        rd_data = 8'h00;
      endcase
   end

endmodule

`default_nettype wire

// File: design/vga_mode_select.sv
`timescale 1ns/1ps
`default_nettype none

module vga_mode_select import system_pkg::*; (
   input  wire       sys_clk,
   input  wire       reset_n,
   input  wire       key_mode,
   output vga_mode_e vga_mode
);

   logic key_meta;
   logic key_sync;
   logic key_prev;
   logic key_release;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         key_meta <= 1'b0;
         key_sync <= 1'b0;
         key_prev <= 1'b0;
      end else begin
         key_meta <= key_mode;
         key_sync <= key_meta;
         key_prev <= key_sync;
      end
   end

   assign key_release = key_prev & ~key_sync;  // high to low

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         vga_mode <= VGA_MODE_1920x1080;
      end else if (key_release) begin
         case (vga_mode)
            VGA_MODE_640x480: vga_mode <= VGA_MODE_800x600;
            VGA_MODE_800x600: vga_mode <= VGA_MODE_1920x1080;
            default:          vga_mode <= VGA_MODE_640x480;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: design/system.sv
`timescale 1ns/1ps
`default_nettype none

module system import system_pkg::*; (
   input  wire                 sys_clk,
   input  wire                 reset_n,
   input  wire cpu_bus_t       cpu_bus,
   output logic [7:0]          rd_data,
   output logic                ready,
   input  wire                 key_mode,
   input  wire [BUTTON_W-1:0]  buttons,
   output vga_mode_e           vga_mode   // for the video chip
);

   logic [ROM_ADDR_W-1:0] rom_addr;
   logic [7:0]            rom_rd_data;
   logic [RAM_ADDR_W-1:0] ram_addr;
   logic [7:0]            ram_wr_data;
   logic                  ram_wr_en;
   logic [7:0]            ram_rd_data;
   logic [IO_ADDR_W-1:0]  io_addr;
   logic [7:0]            io_wr_data;
   logic                  io_wr_en;
   logic [7:0]            io_rd_data;

   bus_ctrl u_bus_ctrl (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .cpu_bus     (cpu_bus),
      .rd_data     (rd_data),
      .ready       (ready),
      .rom_addr    (rom_addr),
      .rom_rd_data (rom_rd_data),
      .ram_addr    (ram_addr),
      .ram_wr_data (ram_wr_data),
      .ram_wr_en   (ram_wr_en),
      .ram_rd_data (ram_rd_data),
      .io_addr     (io_addr),
      .io_wr_data  (io_wr_data),
      .io_wr_en    (io_wr_en),
      .io_rd_data  (io_rd_data)
   );

   rom u_rom (
      .sys_clk (sys_clk),
      .addr    (rom_addr),
      .rd_data (rom_rd_data)
   );

   // block ram stands in for external sram
   spram u_ram (
      .sys_clk (sys_clk),
      .addr    (ram_addr),
      .wr_data (ram_wr_data),
      .wr_en   (ram_wr_en),
      .rd_data (ram_rd_data)
   );

   io_board u_io (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .addr     (io_addr),
      .wr_data  (io_wr_data),
      .wr_en    (io_wr_en),
      .rd_data  (io_rd_data),
      .buttons  (buttons),
      .vga_mode (vga_mode)
   );

   vga_mode_select u_mode (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .key_mode (key_mode),
      .vga_mode (vga_mode)
   );

endmodule

`default_nettype wire

// File: sim/tb_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_system import system_pkg::*; ();

   localparam int          MAX_CYCLES = 4000;  // a few times the directed tests
   localparam logic [15:0] IO_BASE    = 16'h9200;

   logic                sys_clk;
   logic                reset_n;
   cpu_bus_t            cpu_bus;
   logic [7:0]          rd_data;
   logic                ready;
   logic                key_mode;
   logic [BUTTON_W-1:0] buttons;
   vga_mode_e           vga_mode;
   integer              errors;
   integer              cycle_count;
   logic [7:0]          rom_model [0:(2**ROM_ADDR_W)-1];
   logic [7:0]          ram_model [0:36863];  // 0x0000 to 0x8fff

   system DUT (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .cpu_bus  (cpu_bus),
      .rd_data  (rd_data),
      .ready    (ready),
      .key_mode (key_mode),
      .buttons  (buttons),
      .vga_mode (vga_mode)
   );

   always #50 sys_clk = ~sys_clk;

   task automatic log_mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      errors = errors + 1;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge sys_clk);
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge sys_clk);
      cpu_bus.addr    = addr;
      cpu_bus.wr_data = data;
      cpu_bus.wr_en   = 1'b1;
      @(negedge sys_clk);
      cpu_bus.wr_en = 1'b0;
      if (addr <= RAM_LAST)
         ram_model[addr] = data;
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
      int waited;
      @(negedge sys_clk);
      cpu_bus.addr   = addr;
      cpu_bus.rd_req = 1'b1;
      @(negedge sys_clk);
      cpu_bus.rd_req = 1'b0;
      if (ready !== 1'b0)
         log_mismatch($sformatf("ready not low after read request to %h", addr));
      waited = 0;
      @(negedge sys_clk);
      while (ready !== 1'b1 && waited < 8) begin
         @(negedge sys_clk);
         waited = waited + 1;
      end
      if (ready !== 1'b1) begin
         $display("error at %0t: ready never came back after a read of %h", $time, addr);
         errors = errors + 1;
      end else if (waited != 0) begin
         log_mismatch($sformatf("ready back %0d cycles late, address %h", waited, addr));
      end
      data = rd_data;  // held while addr stays put
   endtask

   task automatic expect_read(input logic [15:0] addr, input logic [7:0] exp);
      logic [7:0] got;
      bus_read(addr, got);
      if (got !== exp)
         log_mismatch($sformatf("read %h got %h expected %h", addr, got, exp));
   endtask

   task automatic reset_and_rom_reads();
      int i;
      if (ready !== 1'b1)
         log_mismatch("ready not high after reset");
      if (vga_mode !== VGA_MODE_1920x1080)
         log_mismatch($sformatf("vga_mode %0d after reset", vga_mode));
      for (i = 0; i < 24; i = i + 1)
         expect_read(ROM_BASE + i, rom_model[i]);
      // 8 KB rom repeats across the 16 KB window
      expect_read(16'hE000, rom_model[0]);
      expect_read(16'hDFFF, 8'h00);  // past the loaded bytes
   endtask

   task automatic ram_readback();
      logic [15:0] addrs [$];
      logic [15:0] a;
      int          i;
      addrs.push_back(16'h0000);
      addrs.push_back(RAM_LAST);
      for (i = 0; i < 62; i = i + 1) begin
         a = 16'($urandom % 36864);
         addrs.push_back(a);
      end
      for (i = 0; i < addrs.size(); i = i + 1)
         bus_write(addrs[i], 8'($urandom));
      for (i = 0; i < addrs.size(); i = i + 1)
         expect_read(addrs[i], ram_model[addrs[i]]);
      bus_write(16'hC005, ~rom_model[5]);
      expect_read(16'hC005, rom_model[5]);
   endtask

   task automatic unmapped_access();
      expect_read(16'h9000, UNMAPPED_DATA);
      expect_read(16'h91FF, UNMAPPED_DATA);
      expect_read(16'hB000, UNMAPPED_DATA);
      bus_write(16'h9002, 8'h3C);  // low nibble matches the scratch index
      bus_write(16'h91F2, 8'h3C);
      bus_write(16'hB000, 8'h3C);
      expect_read(16'hB000, UNMAPPED_DATA);
      expect_read(16'h0000, ram_model[0]);
      expect_read(RAM_LAST, ram_model[RAM_LAST]);
      expect_read(IO_BASE + IO_REG_SCRATCH, 8'h00);
   endtask

   task automatic io_scratch_alias();
      bus_write(IO_BASE + IO_REG_SCRATCH, 8'h5A);
      expect_read(IO_BASE + IO_REG_SCRATCH, 8'h5A);
      expect_read(16'h92F2, 8'h5A);
      bus_write(16'h92F2, 8'hC3);
      expect_read(IO_BASE + IO_REG_SCRATCH, 8'hC3);
      bus_write(IO_BASE + 16'h5, 8'h77);  // no register here
      expect_read(IO_BASE + 16'h5, 8'h00);
      expect_read(IO_BASE + IO_REG_SCRATCH, 8'hC3);
   endtask

   task automatic button_latch();
      logic [7:0] pattern;
      logic [7:0] mask;
      pattern = 8'h16;
      mask    = 8'h06;
      @(negedge sys_clk);
      buttons = pattern[BUTTON_W-1:0];
      wait_cycles(4);
      expect_read(IO_BASE + IO_REG_BUTTONS, pattern);
      @(negedge sys_clk);
      buttons = '0;
      wait_cycles(4);
      expect_read(IO_BASE + IO_REG_BUTTONS, 8'h00);
      expect_read(IO_BASE + IO_REG_PRESSED, pattern);  // sticky after release
      @(negedge sys_clk);
      buttons = 5'b00001;
      wait_cycles(4);
      buttons = '0;
      wait_cycles(4);
      expect_read(IO_BASE + IO_REG_PRESSED, pattern | 8'h01);
      bus_write(IO_BASE + IO_REG_PRESSED, mask);
      expect_read(IO_BASE + IO_REG_PRESSED, (pattern | 8'h01) & ~mask);
   endtask

   task automatic press_mode_key();
      @(negedge sys_clk);
      key_mode = 1'b1;
      wait_cycles(8);
      key_mode = 1'b0;  // release steps the mode
      wait_cycles(8);
   endtask

   task automatic mode_key_cycle();
      logic [1:0] expected [0:3];
      int         i;
      expected[0] = VGA_MODE_640x480;
      expected[1] = VGA_MODE_800x600;
      expected[2] = VGA_MODE_1920x1080;
      expected[3] = VGA_MODE_640x480;
      for (i = 0; i < 4; i = i + 1) begin
         press_mode_key();
         if (vga_mode !== expected[i])
            log_mismatch($sformatf("vga_mode %0d after release %0d", vga_mode, i + 1));
         expect_read(IO_BASE + IO_REG_MODE, {6'b000000, expected[i]});
      end
      @(negedge sys_clk);
      key_mode = 1'b1;
      wait_cycles(20);
      if (vga_mode !== expected[3])
         log_mismatch("vga_mode moved while the key was held");
      expect_read(IO_BASE + IO_REG_MODE, {6'b000000, expected[3]});
   endtask

   initial begin
      sys_clk  = 1'b0;
      reset_n  = 1'b0;
      cpu_bus  = '0;
      key_mode = 1'b0;
      buttons  = '0;
      errors   = 0;
      void'($urandom(74));
      for (int i = 0; i < 2**ROM_ADDR_W; i = i + 1)
         rom_model[i] = 8'h00;
      $readmemh("design/rom_init.hex", rom_model);
      repeat (8) @(posedge sys_clk);
      @(negedge sys_clk);
      reset_n = 1'b1;
      @(negedge sys_clk);
      reset_and_rom_reads();
      ram_readback();
      unmapped_access();
      io_scratch_alias();
      button_latch();
      mode_key_cycle();
      $display("run finished with %0d errors", errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge sys_clk);
         cycle_count = cycle_count + 1;
      end
      $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
      $display("run finished with %0d errors", errors);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: design/rom_init.hex
// one hex byte per line, rom offsets 0x00 to 0x17
78
D8
A2
FF
9A
A9
00
8D
02
92
AD
00
92
8D
00
02
A9
03
8D
01
92
4C
0C
C0

// File: list.f
common/system_pkg.sv
design/bus_ctrl.sv
design/rom.sv
design/spram.sv
design/io_board.sv
design/vga_mode_select.sv
design/system.sv
sim/tb_system.sv
